// ==== files.f ====
+incdir+logic
logic/audio_pkg.sv
logic/audio_regs.sv
logic/audio_channel.sv
logic/dma_arbiter.sv
logic/audio_mixer.sv
logic/audio_controller.sv
testbench/tb_audio_controller.sv

// ==== logic/audio_channel.sv ====
/*
 One playback channel. Fetches stereo words into a small circular
 buffer and plays one per sample tick, scaled by vol/16.
 A start empties the buffer and replaces the running transfer.
*/

`timescale 1ns/10ps

`include "audio_settings.svh"

module audio_channel import audio_pkg::*; (
	input  logic i_clock,
	input  logic i_rst,

	input  logic i_start,
	input  dma_addr_t i_start_address,
	input  count_t i_count,
	input  volume_t i_volume,

	output logic o_fetch_request,
	output dma_addr_t o_fetch_address,
	input  logic i_grant,
	input  word_t i_dma_rdata,

	input  logic i_sample_tick,
	output logic o_busy,
	output stereo_t o_sample
);

	localparam int PTR_BITS = $clog2(`BUFFER_DEPTH);

	word_t buffer [`BUFFER_DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS:0] level;
	count_t remaining;
	stereo_t head_word;
	logic push;
	logic pop;

	function automatic sample_t scale(sample_t sample, volume_t volume);
		logic signed [`SAMPLE_WIDTH+`VOLUME_WIDTH:0] product;
		product = sample * $signed({1'b0, volume});
		return sample_t'(product >>> `VOLUME_WIDTH);
	endfunction

	assign o_fetch_request = (remaining != '0) && (level < (PTR_BITS+1)'(`BUFFER_DEPTH));
	assign o_busy = (remaining != '0) || (level != '0);
	assign head_word = buffer[rd_ptr];

	assign push = i_grant && o_fetch_request;
	assign pop = i_sample_tick && (level != '0);

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			remaining <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
			o_sample <= '0;
		end else begin
			// Empty buffer plays silence
			if (i_sample_tick) begin
				if (level != '0) begin
					o_sample.left <= scale(head_word.left, i_volume);
					o_sample.right <= scale(head_word.right, i_volume);
				end else begin
					o_sample <= '0;
				end
			end

			if (i_start) begin
				o_fetch_address <= i_start_address;
				remaining <= i_count;
				wr_ptr <= '0;
				rd_ptr <= '0;
				level <= '0;
			end else begin
				if (push) begin
					wr_ptr <= wr_ptr + 1'b1;
					o_fetch_address <= o_fetch_address + 1'b1;
					remaining <= remaining - 1'b1;
				end
				if (pop)
					rd_ptr <= rd_ptr + 1'b1;
				if (push && !pop)
					level <= level + 1'b1;
				else if (pop && !push)
					level <= level - 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (push && !i_start)
			buffer[wr_ptr] <= i_dma_rdata;
	end

endmodule

// ==== logic/audio_controller.sv ====
/*
 Multi-channel audio playback controller, top level.
 i_sample_tick is a one-cycle pulse; mixed output follows two cycles later.
 DMA addresses count in words, each word one stereo sample pair.
*/

`timescale 1ns/10ps

`include "audio_settings.svh"

module audio_controller import audio_pkg::*; (
	input  logic i_clock,
	input  logic i_rst,

	// CPU port
	input  logic i_request,
	input  logic i_rw,
	input  logic [7:0] i_address,
	input  word_t i_wdata,
	output word_t o_rdata,
	output logic o_ready,

	// DMA master
	output logic o_dma_request,
	output dma_addr_t o_dma_address,
	input  logic i_dma_ready,
	input  word_t i_dma_rdata,

	input  logic i_sample_tick,
	output sample_t o_sample_left,
	output sample_t o_sample_right,
	output logic o_interrupt
);

	chan_mask_t start;
	dma_addr_t [`AUDIO_CHANNELS-1:0] start_address;
	count_t [`AUDIO_CHANNELS-1:0] count;
	volume_t [`AUDIO_CHANNELS-1:0] volume;
	chan_mask_t busy;
	chan_mask_t fetch_request;
	dma_addr_t [`AUDIO_CHANNELS-1:0] fetch_address;
	chan_mask_t grant;
	stereo_t [`AUDIO_CHANNELS-1:0] samples;

	audio_regs u_regs (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.i_busy(busy),
		.o_interrupt(o_interrupt),
		.o_start(start),
		.o_start_address(start_address),
		.o_count(count),
		.o_volume(volume)
	);

	for (genvar c = 0; c < `AUDIO_CHANNELS; c++) begin : g_channel
		audio_channel u_channel (
			.i_clock(i_clock),
			.i_rst(i_rst),
			.i_start(start[c]),
			.i_start_address(start_address[c]),
			.i_count(count[c]),
			.i_volume(volume[c]),
			.o_fetch_request(fetch_request[c]),
			.o_fetch_address(fetch_address[c]),
			.i_grant(grant[c]),
			.i_dma_rdata(i_dma_rdata),
			.i_sample_tick(i_sample_tick),
			.o_busy(busy[c]),
			.o_sample(samples[c])
		);
	end

	dma_arbiter u_arbiter (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_fetch_request(fetch_request),
		.i_fetch_address(fetch_address),
		.o_grant(grant),
		.o_dma_request(o_dma_request),
		.o_dma_address(o_dma_address),
		.i_dma_ready(i_dma_ready)
	);

	audio_mixer u_mixer (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_samples(samples),
		.o_sample_left(o_sample_left),
		.o_sample_right(o_sample_right)
	);

endmodule

// ==== logic/audio_mixer.sv ====
/*
 Stereo mixer. Sums all channel samples and clamps to the sample range.
 Registered every cycle; inputs only move on sample ticks.
*/

`timescale 1ns/10ps

`include "audio_settings.svh"

module audio_mixer import audio_pkg::*; (
	input  logic i_clock,
	input  logic i_rst,

	input  stereo_t [`AUDIO_CHANNELS-1:0] i_samples,
	output sample_t o_sample_left,
	output sample_t o_sample_right
);

	localparam int ACC_WIDTH = `SAMPLE_WIDTH + $clog2(`AUDIO_CHANNELS);
	localparam sample_t SAMPLE_MAX = {1'b0, {(`SAMPLE_WIDTH-1){1'b1}}};
	localparam sample_t SAMPLE_MIN = {1'b1, {(`SAMPLE_WIDTH-1){1'b0}}};

	typedef logic signed [ACC_WIDTH-1:0] acc_t;

	acc_t sum_left;
	acc_t sum_right;

	function automatic sample_t saturate(acc_t sum);
		if (sum > acc_t'(SAMPLE_MAX))
			return SAMPLE_MAX;
		else if (sum < acc_t'(SAMPLE_MIN))
			return SAMPLE_MIN;
		return sample_t'(sum);
	endfunction

	always_comb begin
		sum_left = '0;
		sum_right = '0;
		for (int c = 0; c < `AUDIO_CHANNELS; c++) begin
			sum_left = sum_left + acc_t'(i_samples[c].left);
			sum_right = sum_right + acc_t'(i_samples[c].right);
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_sample_left <= '0;
			o_sample_right <= '0;
		end else begin
			o_sample_left <= saturate(sum_left);
			o_sample_right <= saturate(sum_right);
		end
	end

endmodule

// ==== logic/audio_pkg.sv ====
/*
 Shared types of the audio playback controller.
 A stereo word keeps the left sample in the low half.
*/

`include "audio_settings.svh"

package audio_pkg;

	typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t;

	// Left in the low half of the word
	typedef struct packed {
		sample_t right;
		sample_t left;
	} stereo_t;

	typedef logic [`WORD_WIDTH-1:0] word_t;
	typedef logic [`WORD_WIDTH-1:0] dma_addr_t;
	typedef logic [`COUNT_WIDTH-1:0] count_t;

	// 15 is full scale
	typedef logic [`VOLUME_WIDTH-1:0] volume_t;

	typedef logic [$clog2(`AUDIO_CHANNELS)-1:0] chan_idx_t;
	typedef logic [`AUDIO_CHANNELS-1:0] chan_mask_t;

endpackage

// ==== logic/audio_regs.sv ====
/*
 CPU register block. The CPU holds i_request until o_ready answers.
 Writes outside the channel range are acknowledged and dropped.
 Only REG_BUSY reads back data; every other read returns zero.
*/

`timescale 1ns/10ps

`include "audio_settings.svh"

module audio_regs import audio_pkg::*; (
	input  logic i_clock,
	input  logic i_rst,

	input  logic i_request,
	input  logic i_rw,
	input  logic [7:0] i_address,
	input  word_t i_wdata,
	output word_t o_rdata,
	output logic o_ready,

	input  chan_mask_t i_busy,
	output logic o_interrupt,

	output chan_mask_t o_start,
	output dma_addr_t [`AUDIO_CHANNELS-1:0] o_start_address,
	output count_t [`AUDIO_CHANNELS-1:0] o_count,
	output volume_t [`AUDIO_CHANNELS-1:0] o_volume
);

	localparam int OFFSET_BITS = $clog2(`REG_STRIDE);

	chan_idx_t chan;
	logic [OFFSET_BITS-1:0] offset;
	logic in_range;
	logic access;
	logic setup_write;
	chan_mask_t busy_prev;

	assign chan = i_address[OFFSET_BITS +: $bits(chan_idx_t)];
	assign offset = i_address[OFFSET_BITS-1:0];
	assign in_range = (i_address < 8'(`AUDIO_CHANNELS * `REG_STRIDE));

	// New access seen while not yet acknowledged
	assign access = i_request && !o_ready;
	assign setup_write = access && i_rw && in_range;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_ready <= 1'b0;
			o_start <= '0;
			o_volume <= {`AUDIO_CHANNELS{volume_t'('1)}};
			busy_prev <= '0;
			o_interrupt <= 1'b0;
		end else begin
			o_start <= '0;
			if (access) begin
				o_ready <= 1'b1;
				if (setup_write && offset == OFFSET_BITS'(`REG_OFS_COUNT))
					o_start[chan] <= 1'b1;
				if (setup_write && offset == OFFSET_BITS'(`REG_OFS_VOLUME))
					o_volume[chan] <= i_wdata[`VOLUME_WIDTH-1:0];
			end else if (!i_request) begin
				o_ready <= 1'b0;
			end

			// Pulse when any channel drops out of busy
			busy_prev <= i_busy;
			o_interrupt <= |(busy_prev & ~i_busy);
		end
	end

	always_ff @(posedge i_clock) begin
		if (setup_write && offset == OFFSET_BITS'(`REG_OFS_ADDRESS))
			o_start_address[chan] <= i_wdata;
		if (setup_write && offset == OFFSET_BITS'(`REG_OFS_COUNT))
			o_count[chan] <= i_wdata[`COUNT_WIDTH-1:0];
		if (access && !i_rw)
			o_rdata <= (i_address == `REG_BUSY) ? word_t'(i_busy) : '0;
	end

endmodule

// ==== logic/audio_settings.svh ====
/*
 Build settings of the audio playback controller.
 AUDIO_CHANNELS and BUFFER_DEPTH must be powers of two, at least 2.
 Registers of channel c sit at c * REG_STRIDE plus the offsets below.
*/

`ifndef AUDIO_SETTINGS_SVH
`define AUDIO_SETTINGS_SVH

`define AUDIO_CHANNELS 4
`define SAMPLE_WIDTH 16
`define VOLUME_WIDTH 4
`define COUNT_WIDTH 24
`define WORD_WIDTH 32
`define BUFFER_DEPTH 4

`define REG_STRIDE 4
`define REG_OFS_ADDRESS 0
`define REG_OFS_COUNT 1
`define REG_OFS_VOLUME 2
`define REG_BUSY 8'h01

`endif

// ==== logic/dma_arbiter.sv ====
/*
 Round-robin owner of the DMA master, one fetch in flight.
 A word whose channel was restarted meanwhile is dropped, since
 the channel's address no longer matches the one on the bus.
*/

`timescale 1ns/10ps

`include "audio_settings.svh"

module dma_arbiter import audio_pkg::*; (
	input  logic i_clock,
	input  logic i_rst,

	input  chan_mask_t i_fetch_request,
	input  dma_addr_t [`AUDIO_CHANNELS-1:0] i_fetch_address,
	output chan_mask_t o_grant,

	output logic o_dma_request,
	output dma_addr_t o_dma_address,
	input  logic i_dma_ready
);

	chan_idx_t ptr;
	chan_idx_t next_ptr;

	// Channel count is a power of two so the pointer wraps by itself
	assign next_ptr = ptr + 1'b1;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			ptr <= '0;
			o_dma_request <= 1'b0;
		end else if (o_dma_request) begin
			// Hold pointer and address until the memory answers
			if (i_dma_ready) begin
				o_dma_request <= 1'b0;
				ptr <= next_ptr;
			end
		end else if (i_fetch_request[ptr]) begin
			o_dma_request <= 1'b1;
			o_dma_address <= i_fetch_address[ptr];
		end else begin
			ptr <= next_ptr;
		end
	end

	always_comb begin
		o_grant = '0;
		if (o_dma_request && i_dma_ready && i_fetch_request[ptr]
				&& i_fetch_address[ptr] == o_dma_address)
			o_grant[ptr] = 1'b1;
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the audio controller testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f files.f --top-module tb_audio_controller -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TEST PASSED"; then
	exit 0
fi
exit 1

// ==== testbench/audio_stim.txt ====
// kind a b, hex. 1 memory word (addr, data), 2 register write (addr, data),
// 3 register read (addr, expected), 4 tick (expected left, right), 5 wait a cycles, 6 interrupts
3 01 0
1 10 80007FFF
1 11 00100100
1 12 FFF0FF00
1 13 00000001
1 20 80007FFF
1 21 02000040
1 22 0003FFFD
1 23 12340000
1 30 7FFF7FFF
1 31 40004000
1 40 77777777
1 41 66666666
1 42 55555555
1 43 44444444
1 50 01000100
1 51 FFFFFFFF
1 52 0020FFE0
2 00 10
2 02 F
2 01 4
2 04 20
2 06 8
2 05 4
2 08 30
2 0A 0
2 09 2
2 0C 40
2 0E 4
2 0D 4
2 0C 50
2 0D 3
3 01 F
5 100 0
4 7FFF 8000
4 010F 010E
4 FF06 FFFA
4 0000 091A
4 0000 0000
4 0000 0000
3 01 0
6 3 0

// ==== testbench/tb_audio_controller.sv ====
/*
 Testbench for the audio playback controller.
 Runs from the project root and reads testbench/audio_stim.txt.
 Memory model serves word addresses 0..255 with 0 to 3 wait cycles.
*/

`timescale 1ns/10ps

`include "audio_settings.svh"

module tb_audio_controller;

	logic i_clock;
	logic i_rst;
	logic i_request;
	logic i_rw;
	logic [7:0] i_address;
	logic [31:0] i_wdata;
	logic [31:0] o_rdata;
	logic o_ready;
	logic o_dma_request;
	logic [31:0] o_dma_address;
	logic i_dma_ready = 1'b0;
	logic [31:0] i_dma_rdata = '0;
	logic i_sample_tick;
	logic signed [15:0] o_sample_left;
	logic signed [15:0] o_sample_right;
	logic o_interrupt;

	int value_errors = 0;
	int protocol_errors = 0;
	int cycles = 0;
	int cycle_limit = 1000000;
	int int_pulses = 0;

	logic [31:0] mem [256];
	int rec_kind [$];
	logic [31:0] rec_a [$];
	logic [31:0] rec_b [$];

	// Mirror of each channel's programmed range and next expected fetch
	logic [31:0] pend_base [`AUDIO_CHANNELS];
	logic [31:0] base [`AUDIO_CHANNELS];
	logic [31:0] stop [`AUDIO_CHANNELS];
	logic [31:0] next_addr [`AUDIO_CHANNELS];
	logic [31:0] old_base [`AUDIO_CHANNELS];
	logic [31:0] old_stop [`AUDIO_CHANNELS];
	logic [31:0] old_next [`AUDIO_CHANNELS];
	int old_until [`AUDIO_CHANNELS];

	logic [7:0] lfsr = 8'd70;
	logic [1:0] wait_left = 2'd0;
	logic last_req = 1'b0;
	logic last_ready = 1'b0;
	logic [31:0] last_addr = '0;
	logic last_int = 1'b0;

	audio_controller uut (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.o_dma_request(o_dma_request),
		.o_dma_address(o_dma_address),
		.i_dma_ready(i_dma_ready),
		.i_dma_rdata(i_dma_rdata),
		.i_sample_tick(i_sample_tick),
		.o_sample_left(o_sample_left),
		.o_sample_right(o_sample_right),
		.o_interrupt(o_interrupt)
	);

	always #20 i_clock = ~i_clock;

	function automatic logic [7:0] lfsr_step(input logic [7:0] state);
		return (state >> 1) ^ (state[0] ? 8'hB8 : 8'h00);
	endfunction

	task automatic expect_value(input logic [31:0] got, input logic [31:0] want,
			input string what);
		assert (got === want) else begin
			value_errors++;
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	always @(posedge i_clock) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			$display("TEST FAILED");
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$finish;
		end
	end

	// Memory answers a held request after a random number of waits
	always @(posedge i_clock) begin : memory_model
		logic [1:0] waits;
		if (i_rst) begin
			i_dma_ready <= 1'b0;
			wait_left <= 2'd0;
		end else if (i_dma_ready) begin
			i_dma_ready <= 1'b0;
			waits = 2'd0;
			for (int k = 0; k < 2; k++) begin
				waits = {waits[0], lfsr[0]};
				lfsr = lfsr_step(lfsr);
			end
			wait_left <= waits;
		end else if (o_dma_request) begin
			if (wait_left == 2'd0) begin
				i_dma_ready <= 1'b1;
				i_dma_rdata <= mem[o_dma_address[7:0]];
			end else begin
				wait_left <= wait_left - 2'd1;
			end
		end
	end

	task automatic check_issue(input logic [31:0] addr);
		logic found;
		found = 1'b0;
		for (int c = 0; c < `AUDIO_CHANNELS; c++) begin
			if (addr >= base[c] && addr < stop[c]) begin
				found = 1'b1;
				expect_value(addr, next_addr[c], "DMA fetch address");
				next_addr[c] = addr + 32'd1;
			end else if (cycles <= old_until[c] && addr >= old_base[c] && addr < old_stop[c]) begin
				// Fetch issued just before a restart took effect
				found = 1'b1;
				expect_value(addr, old_next[c], "DMA fetch address");
				old_next[c] = addr + 32'd1;
			end
		end
		assert (found) else begin
			value_errors++;
			$display("CHECK FAILED at %0t: DMA address %h is outside every active channel",
				$time, addr);
		end
	endtask

	always @(posedge i_clock) begin : bus_monitor
		if (!i_rst) begin
			if (o_dma_request && last_req && !last_ready)
				expect_value(o_dma_address, last_addr, "DMA address during wait");
			// A request right after a completion is a new fetch
			if (o_dma_request && (!last_req || last_ready))
				check_issue(o_dma_address);
			assert (!(o_interrupt && last_int)) else begin
				protocol_errors++;
				$display("Interrupt stayed high for more than one cycle at %0t", $time);
			end
			if (o_interrupt && !last_int)
				int_pulses++;
		end
		last_req = o_dma_request;
		last_ready = i_dma_ready;
		last_addr = o_dma_address;
		last_int = o_interrupt;
	end

	task automatic reg_access(input logic rw, input logic [7:0] addr, input logic [31:0] data,
			output logic [31:0] rdata);
		int waited;
		@(posedge i_clock);
		i_request <= 1'b1;
		i_rw <= rw;
		i_address <= addr;
		i_wdata <= data;
		waited = 0;
		do begin
			@(posedge i_clock);
			waited++;
		end while (!o_ready);
		assert (waited == 2) else begin
			protocol_errors++;
			$display("o_ready came %0d cycles after the request instead of 1", waited - 1);
		end
		rdata = o_rdata;
		i_request <= 1'b0;
		waited = 0;
		do begin
			@(posedge i_clock);
			waited++;
		end while (o_ready);
		assert (waited == 2) else begin
			protocol_errors++;
			$display("o_ready fell %0d cycles after the request ended instead of 1",
				waited - 1);
		end
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		int c;
		int ofs;
		c = int'(addr) / `REG_STRIDE;
		ofs = int'(addr) % `REG_STRIDE;
		if (c < `AUDIO_CHANNELS && ofs == `REG_OFS_ADDRESS)
			pend_base[c] = data;
		if (c < `AUDIO_CHANNELS && ofs == `REG_OFS_COUNT) begin
			old_base[c] = base[c];
			old_stop[c] = stop[c];
			old_next[c] = next_addr[c];
			old_until[c] = cycles + 6;
			base[c] = pend_base[c];
			stop[c] = pend_base[c] + {8'h00, data[23:0]};
			next_addr[c] = pend_base[c];
		end
		reg_access(1'b1, addr, data, unused);
	endtask

	task automatic play_tick(input logic [31:0] left, input logic [31:0] right);
		@(posedge i_clock);
		i_sample_tick <= 1'b1;
		@(posedge i_clock);
		i_sample_tick <= 1'b0;
		repeat (2) @(posedge i_clock);
		expect_value({16'h0000, o_sample_left}, left, "left mixer output");
		expect_value({16'h0000, o_sample_right}, right, "right mixer output");
		repeat (60) @(posedge i_clock);
	endtask

	initial begin
		int fd;
		int kind;
		int ticks;
		int accesses;
		int settle;
		string line;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] rdata;
		i_clock = 1'b0;
		i_rst = 1'b1;
		i_request = 1'b0;
		i_rw = 1'b0;
		i_address = '0;
		i_wdata = '0;
		i_sample_tick = 1'b0;
		for (int i = 0; i < 256; i++)
			mem[8'(i)] = 32'hC0DE0000 | 32'(i);
		for (int c = 0; c < `AUDIO_CHANNELS; c++) begin
			pend_base[c] = '0;
			base[c] = '0;
			stop[c] = '0;
			next_addr[c] = '0;
			old_base[c] = '0;
			old_stop[c] = '0;
			old_next[c] = '0;
			old_until[c] = 0;
		end

		fd = $fopen("testbench/audio_stim.txt", "r");
		if (fd == 0) begin
			$display("TEST FAILED");
			$display("Cannot open the stimulus file testbench/audio_stim.txt");
			$finish;
		end else begin
			ticks = 0;
			accesses = 0;
			settle = 0;
			while (!$feof(fd)) begin
				if ($fgets(line, fd) != 0 && $sscanf(line, "%h %h %h", kind, a, b) == 3) begin
					rec_kind.push_back(kind);
					rec_a.push_back(a);
					rec_b.push_back(b);
					if (kind == 2 || kind == 3)
						accesses++;
					if (kind == 4)
						ticks++;
					if (kind == 5)
						settle += int'(a);
				end
			end
			$fclose(fd);
			cycle_limit = 2 * ticks * 64 + 8 + 10 * accesses + settle + 64;

			repeat (8) @(posedge i_clock);
			i_rst <= 1'b0;
			@(posedge i_clock);
			@(posedge i_clock);
			expect_value({31'b0, o_ready}, 32'd0, "o_ready after reset");
			expect_value({31'b0, o_dma_request}, 32'd0, "o_dma_request after reset");
			expect_value({31'b0, o_interrupt}, 32'd0, "o_interrupt after reset");
			expect_value({16'h0000, o_sample_left}, 32'd0, "left sample after reset");
			expect_value({16'h0000, o_sample_right}, 32'd0, "right sample after reset");

			for (int r = 0; r < rec_kind.size(); r++) begin
				case (rec_kind[r])
					1: mem[rec_a[r][7:0]] = rec_b[r];
					2: write_reg(rec_a[r][7:0], rec_b[r]);
					3: begin
						reg_access(1'b0, rec_a[r][7:0], '0, rdata);
						expect_value(rdata, rec_b[r], "register read");
					end
					4: play_tick(rec_a[r], rec_b[r]);
					5: repeat (int'(rec_a[r])) @(posedge i_clock);
					6: expect_value(32'(int_pulses), rec_a[r], "interrupt pulse count");
					default: begin
						protocol_errors++;
						$display("Unknown record kind %0d in the stimulus file", rec_kind[r]);
					end
				endcase
			end

			$display("Errors: %0d value mismatches, %0d protocol failures",
				value_errors, protocol_errors);
			if (value_errors + protocol_errors == 0)
				$display("TEST PASSED");
			else
				$display("TEST FAILED");
			$finish;
		end
	end

endmodule
